// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_top
FILELIST  = tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// ==== rtl/rob_branch_check.sv ====
`timescale 1ns/100ps
`include "rob_defines.svh"

module rob_branch_check import rob_pkg::*; (
    input  logic                  brnc_vld,
    input  rob_idx_t              brnc_idx,
    input  brnc_cond_t            brnc_cmp_rslt,
    input  brnc_info_t            brnc_info,
    input  logic [`ROB_DEPTH-1:0] vld,
    input  logic [`ROB_DEPTH-1:0] brnc,
    output logic                  mis_pred,
    output logic                  cmt_brnc,
    output rob_idx_t              rollback_idx
);

    logic hit;
    logic taken;

    // results for anything but a live branch entry are dropped
    assign hit = brnc_vld && vld[brnc_idx] && brnc[brnc_idx];

    // actual outcome: stored condition matches the compare result
    assign taken = (brnc_info.cond == brnc_cmp_rslt);

    assign mis_pred = hit && (brnc_info.pred != taken);
    assign cmt_brnc = hit && (brnc_info.pred == taken);

    // first entry of the following group, 60..63 wraps to 0
    assign rollback_idx = (brnc_idx | rob_idx_t'(`ROB_GRP - 1)) + 1'b1;

endmodule

// ==== rtl/rob_commit.sv ====
`timescale 1ns/100ps
`include "rob_defines.svh"

module rob_commit import rob_pkg::*; (
    input  rob_idx_t                  head,
    input  logic [`ROB_DEPTH-1:0]     vld,
    input  logic [`ROB_DEPTH-1:0]     done,
    input  logic [`ROB_DEPTH-1:0]     reg_wrt,
    input  preg_t [`ROB_CMT_W-1:0]    head_pregs,
    output logic [2:0]                commit_cnt,
    output logic [2:0]                free_preg_cnt,
    output preg_t [`ROB_CMT_W-1:0]    free_preg
);

    logic [`ROB_CMT_W-1:0] slot_ok;
    logic [`ROB_CMT_W-1:0] slot_rw;
    logic                  run_live;

    // state of the oldest few entries
    always_comb begin
        for (int k = 0; k < `ROB_CMT_W; k++) begin
            slot_ok[k] = vld[rob_idx_t'(head + k)] && done[rob_idx_t'(head + k)];
            slot_rw[k] = reg_wrt[rob_idx_t'(head + k)];
        end
    end

    // run from the head stops at the first unfinished or empty slot;
    // freed numbers are packed into the low slots in age order
    always_comb begin
        commit_cnt    = '0;
        free_preg_cnt = '0;
        free_preg     = '0;
        run_live      = 1'b1;
        for (int k = 0; k < `ROB_CMT_W; k++) begin
            run_live = run_live && slot_ok[k];
            if (run_live) begin
                commit_cnt = commit_cnt + 1'b1;
                if (slot_rw[k]) begin
                    free_preg[free_preg_cnt[1:0]] = head_pregs[k];
                    free_preg_cnt = free_preg_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/rob_defines.svh ====
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// buffer geometry
`define ROB_DEPTH 64
`define ROB_AW 6

// entries written by one allocation
`define ROB_GRP 4

// retire bandwidth per cycle
`define ROB_CMT_W 4

// execution write-back ports
`define ROB_DONE_PORTS 4

// physical register number width
`define ROB_PREG_W 6

`endif

// ==== rtl/rob_field_array.sv ====
`timescale 1ns/100ps
`include "rob_defines.svh"

module rob_field_array import rob_pkg::*; #(
    parameter type payload_t = preg_t,
    parameter int  N_RD      = 1
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr_en,
    input  rob_idx_t                  wr_base,
    input  payload_t [`ROB_GRP-1:0]   wr_data,
    input  rob_idx_t [N_RD-1:0]       rd_idx,
    output payload_t [N_RD-1:0]       rd_data
);

    payload_t mem [`ROB_DEPTH];

    // whole group lands at the tail, wrapping past the last entry
    always_ff @(posedge clk) begin
        if (wr_en && rst_n) begin
            for (int g = 0; g < `ROB_GRP; g++) begin
                mem[rob_idx_t'(wr_base + g)] <= wr_data[g];
            end
        end
    end

    // asynchronous reads
    for (genvar r = 0; r < N_RD; r++) begin : g_rd
        assign rd_data[r] = mem[rd_idx[r]];
    end

endmodule

// ==== rtl/rob_pkg.sv ====
`include "rob_defines.svh"

package rob_pkg;

    // entry index into the buffer
    typedef logic [`ROB_AW-1:0] rob_idx_t;

    // index plus wrap bit, so full and empty can be told apart
    typedef logic [`ROB_AW:0] rob_ptr_t;

    // physical register number
    typedef logic [`ROB_PREG_W-1:0] preg_t;

    // condition code compared against the RF compare result
    typedef logic [1:0] brnc_cond_t;

    // what the front end predicted for a branch
    typedef struct packed {
        logic       pred;
        brnc_cond_t cond;
    } brnc_info_t;

endpackage

// ==== rtl/rob_pointers.sv ====
`timescale 1ns/100ps
`include "rob_defines.svh"

module rob_pointers import rob_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       alloc_vld,
    input  logic       mis_pred,
    input  rob_idx_t   rollback_idx,
    input  logic [2:0] commit_cnt,
    output rob_idx_t   head,
    output rob_ptr_t   tail,
    output logic       rob_full,
    output logic       rob_empty,
    output logic       alloc_en
);

    // head keeps its own wrap bit for the occupancy math
    rob_ptr_t          head_q;
    logic [`ROB_AW:0]  occ;
    logic              rb_wrap;

    assign head = head_q[`ROB_AW-1:0];

    // entries in flight, 0 to 64
    assign occ = tail - head_q;

    assign rob_empty = (occ == '0);
    // not enough room left for a whole group
    assign rob_full  = (occ > (`ROB_DEPTH - `ROB_GRP));

    // the one allocation strobe everyone else sees
    assign alloc_en = alloc_vld && !rob_full && !mis_pred;

    // rollback point numerically above the tail means the tail
    // already wrapped past 63, so the wrap bit goes back as well
    assign rb_wrap = tail[`ROB_AW] ^ (rollback_idx > tail[`ROB_AW-1:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail <= '0;
        end else if (mis_pred) begin
            tail <= {rb_wrap, rollback_idx};
        end else if (alloc_en) begin
            tail <= tail + rob_ptr_t'(`ROB_GRP);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q <= '0;
        end else begin
            head_q <= head_q + rob_ptr_t'(commit_cnt);
        end
    end

endmodule

// ==== rtl/rob_status.sv ====
`timescale 1ns/100ps
`include "rob_defines.svh"

module rob_status import rob_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           alloc_en,
    input  rob_ptr_t                       tail,
    input  logic [`ROB_GRP-1:0]            alloc_reg_wrt,
    input  logic [`ROB_GRP-1:0]            alloc_brnc,
    input  logic [`ROB_DONE_PORTS-1:0]     done_vld,
    input  rob_idx_t [`ROB_DONE_PORTS-1:0] done_idx,
    input  logic                           brnc_vld,
    input  rob_idx_t                       brnc_idx,
    input  logic                           mis_pred,
    input  rob_idx_t                       rollback_idx,
    input  rob_idx_t                       head,
    input  logic [2:0]                     commit_cnt,
    output logic [`ROB_DEPTH-1:0]          vld,
    output logic [`ROB_DEPTH-1:0]          done,
    output logic [`ROB_DEPTH-1:0]          reg_wrt,
    output logic [`ROB_DEPTH-1:0]          brnc
);

    logic [`ROB_DEPTH-1:0] kill_hit;
    logic [`ROB_DEPTH-1:0] bubble_hit;
    logic [`ROB_DEPTH-1:0] alloc_hit;
    logic [`ROB_DEPTH-1:0] done_hit;
    logic [`ROB_DEPTH-1:0] cmt_hit;
    rob_idx_t              kill_len;

    // entries from the rollback point up to the old tail get dropped
    assign kill_len = tail[`ROB_AW-1:0] - rollback_idx;

    always_comb begin
        for (int e = 0; e < `ROB_DEPTH; e++) begin
            kill_hit[e]   = mis_pred && (rob_idx_t'(e - rollback_idx) < kill_len);
            // younger neighbours of the branch inside its own group
            bubble_hit[e] = mis_pred && (e / `ROB_GRP == brnc_idx / `ROB_GRP)
                            && (e > brnc_idx);
            alloc_hit[e]  = alloc_en && (rob_idx_t'(e - tail[`ROB_AW-1:0]) < `ROB_GRP);
            cmt_hit[e]    = (rob_idx_t'(e - head) < commit_cnt);
            // a resolved branch is finished whichever way it went
            done_hit[e]   = brnc_vld && (brnc_idx == rob_idx_t'(e)) && brnc[e];
            for (int p = 0; p < `ROB_DONE_PORTS; p++) begin
                if (done_vld[p] && (done_idx[p] == rob_idx_t'(e))) begin
                    done_hit[e] = 1'b1;
                end
            end
            // only pending entries take a completion
            done_hit[e] = done_hit[e] && vld[e] && !done[e];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld     <= '0;
            done    <= '0;
            reg_wrt <= '0;
            brnc    <= '0;
        end else begin
            for (int e = 0; e < `ROB_DEPTH; e++) begin
                if (kill_hit[e] || cmt_hit[e] && !(bubble_hit[e] || alloc_hit[e]
                                                   || done_hit[e])) begin
                    vld[e]     <= 1'b0;
                    done[e]    <= 1'b0;
                    reg_wrt[e] <= 1'b0;
                    brnc[e]    <= 1'b0;
                end else if (bubble_hit[e]) begin
                    // squashed in place, retires without freeing anything
                    done[e]    <= 1'b1;
                    reg_wrt[e] <= 1'b0;
                    brnc[e]    <= 1'b0;
                end else if (alloc_hit[e]) begin
                    vld[e]     <= 1'b1;
                    reg_wrt[e] <= alloc_reg_wrt[e % `ROB_GRP];
                    brnc[e]    <= alloc_brnc[e % `ROB_GRP];
                    // nothing to wait for, e.g. a nop
                    done[e]    <= !(alloc_reg_wrt[e % `ROB_GRP] || alloc_brnc[e % `ROB_GRP]);
                end else if (done_hit[e]) begin
                    done[e]    <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/rob_top.sv ====
`timescale 1ns/100ps
`include "rob_defines.svh"

module rob_top import rob_pkg::*; (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              alloc_vld,
    input  logic [`ROB_GRP-1:0]               alloc_reg_wrt,
    input  logic [`ROB_GRP-1:0]               alloc_brnc,
    input  logic [`ROB_GRP-1:0]               alloc_brnc_pred,
    input  brnc_cond_t [`ROB_GRP-1:0]         alloc_brnc_cond,
    input  preg_t [`ROB_GRP-1:0]              alloc_free_preg,
    input  logic [`ROB_DONE_PORTS-1:0]        done_vld,
    input  rob_idx_t [`ROB_DONE_PORTS-1:0]    done_idx,
    input  logic                              brnc_vld,
    input  rob_idx_t                          brnc_idx,
    input  brnc_cond_t                        brnc_cmp_rslt,
    output rob_ptr_t                          next_idx,
    output logic                              rob_full,
    output logic                              rob_empty,
    output logic                              mis_pred,
    output rob_idx_t                          mis_pred_idx,
    output logic                              cmt_brnc,
    output logic [2:0]                        commit_cnt,
    output logic [2:0]                        free_preg_cnt,
    output preg_t [`ROB_CMT_W-1:0]            free_preg
);

    rob_idx_t                   head;
    rob_idx_t                   rollback_idx;
    logic                       alloc_en;
    logic [`ROB_DEPTH-1:0]      vld;
    logic [`ROB_DEPTH-1:0]      done;
    logic [`ROB_DEPTH-1:0]      reg_wrt;
    logic [`ROB_DEPTH-1:0]      brnc;
    rob_idx_t [`ROB_CMT_W-1:0]  head_win;
    preg_t [`ROB_CMT_W-1:0]     head_pregs;
    brnc_info_t [`ROB_GRP-1:0]  alloc_brnc_info;
    brnc_info_t                 brnc_info;

    // pack prediction and condition per lane
    for (genvar g = 0; g < `ROB_GRP; g++) begin : g_lane
        assign alloc_brnc_info[g] = '{pred: alloc_brnc_pred[g], cond: alloc_brnc_cond[g]};
    end

    // the four oldest slots, wrapping past 63
    for (genvar c = 0; c < `ROB_CMT_W; c++) begin : g_win
        assign head_win[c] = head + rob_idx_t'(c);
    end

    assign mis_pred_idx = brnc_idx;

    rob_pointers rob_pointers_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_vld    (alloc_vld),
        .mis_pred     (mis_pred),
        .rollback_idx (rollback_idx),
        .commit_cnt   (commit_cnt),
        .head         (head),
        .tail         (next_idx),
        .rob_full     (rob_full),
        .rob_empty    (rob_empty),
        .alloc_en     (alloc_en)
    );

    rob_status rob_status_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_en      (alloc_en),
        .tail          (next_idx),
        .alloc_reg_wrt (alloc_reg_wrt),
        .alloc_brnc    (alloc_brnc),
        .done_vld      (done_vld),
        .done_idx      (done_idx),
        .brnc_vld      (brnc_vld),
        .brnc_idx      (brnc_idx),
        .mis_pred      (mis_pred),
        .rollback_idx  (rollback_idx),
        .head          (head),
        .commit_cnt    (commit_cnt),
        .vld           (vld),
        .done          (done),
        .reg_wrt       (reg_wrt),
        .brnc          (brnc)
    );

    rob_field_array #(.payload_t(preg_t), .N_RD(`ROB_CMT_W)) preg_array_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (alloc_en),
        .wr_base (next_idx[`ROB_AW-1:0]),
        .wr_data (alloc_free_preg),
        .rd_idx  (head_win),
        .rd_data (head_pregs)
    );

    rob_field_array #(.payload_t(brnc_info_t), .N_RD(1)) brnc_array_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (alloc_en),
        .wr_base (next_idx[`ROB_AW-1:0]),
        .wr_data (alloc_brnc_info),
        .rd_idx  (brnc_idx),
        .rd_data (brnc_info)
    );

    rob_branch_check rob_branch_check_i (
        .brnc_vld      (brnc_vld),
        .brnc_idx      (brnc_idx),
        .brnc_cmp_rslt (brnc_cmp_rslt),
        .brnc_info     (brnc_info),
        .vld           (vld),
        .brnc          (brnc),
        .mis_pred      (mis_pred),
        .cmt_brnc      (cmt_brnc),
        .rollback_idx  (rollback_idx)
    );

    rob_commit rob_commit_i (
        .head          (head),
        .vld           (vld),
        .done          (done),
        .reg_wrt       (reg_wrt),
        .head_pregs    (head_pregs),
        .commit_cnt    (commit_cnt),
        .free_preg_cnt (free_preg_cnt),
        .free_preg     (free_preg)
    );

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/rob_pkg.sv
rtl/rob_pointers.sv
rtl/rob_status.sv
rtl/rob_field_array.sv
rtl/rob_branch_check.sv
rtl/rob_commit.sv
rtl/rob_top.sv
tb/tb_clkgen.sv
tb/rob_props.sv
tb/tb_top.sv

// ==== tb/rob_props.sv ====
`timescale 1ns/100ps

module rob_props (
    input logic       clk,
    input logic       rst_n,
    input logic       rob_full,
    input logic       rob_empty,
    input logic [2:0] commit_cnt,
    input logic [2:0] free_preg_cnt
);

    a_full_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(rob_full && rob_empty))
        else $error("rob_full and rob_empty high together");

    a_cmt_max: assert property (@(posedge clk) disable iff (!rst_n)
        commit_cnt <= 3'd4)
        else $error("commit_cnt above four");

    // every freed register belongs to a committing entry
    a_free_le_cmt: assert property (@(posedge clk) disable iff (!rst_n)
        free_preg_cnt <= commit_cnt)
        else $error("free_preg_cnt above commit_cnt");

endmodule

bind rob_top rob_props rob_props_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .rob_full      (rob_pointers_i.rob_full),
    .rob_empty     (rob_pointers_i.rob_empty),
    .commit_cnt    (rob_commit_i.commit_cnt),
    .free_preg_cnt (rob_commit_i.free_preg_cnt)
);

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held over the first three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #5 rst_n = 1'b1;
    end

endmodule

// ==== tb/tb_top.sv ====
`timescale 1ns/100ps
`include "rob_defines.svh"

module tb_top import rob_pkg::*; ();

    // stimulus modes
    localparam int M_FILL = 0;
    localparam int M_RAND = 1;
    localparam int M_BR_OK = 2;
    localparam int M_BR_BAD = 3;
    localparam int M_PRESS = 4;
    localparam int TOTAL_CYC = 17 + 200 + 200 + 200 + 150 + 1000;

    logic                           clk;
    logic                           rst_n;
    logic                           alloc_vld;
    logic [`ROB_GRP-1:0]            alloc_reg_wrt;
    logic [`ROB_GRP-1:0]            alloc_brnc;
    logic [`ROB_GRP-1:0]            alloc_brnc_pred;
    brnc_cond_t [`ROB_GRP-1:0]      alloc_brnc_cond;
    preg_t [`ROB_GRP-1:0]           alloc_free_preg;
    logic [`ROB_DONE_PORTS-1:0]     done_vld;
    rob_idx_t [`ROB_DONE_PORTS-1:0] done_idx;
    logic                           brnc_vld;
    rob_idx_t                       brnc_idx;
    brnc_cond_t                     brnc_cmp_rslt;
    rob_ptr_t                       next_idx;
    logic                           rob_full;
    logic                           rob_empty;
    logic                           mis_pred;
    rob_idx_t                       mis_pred_idx;
    logic                           cmt_brnc;
    logic [2:0]                     commit_cnt;
    logic [2:0]                     free_preg_cnt;
    preg_t [`ROB_CMT_W-1:0]         free_preg;

    // reference model of the buffer
    logic [`ROB_DEPTH-1:0] m_vld;
    logic [`ROB_DEPTH-1:0] m_done;
    logic [`ROB_DEPTH-1:0] m_rw;
    logic [`ROB_DEPTH-1:0] m_br;
    logic [`ROB_DEPTH-1:0] m_pred;
    brnc_cond_t            m_cond [`ROB_DEPTH];
    preg_t                 m_preg [`ROB_DEPTH];
    rob_ptr_t              m_head;
    rob_ptr_t              m_tail;

    logic [15:0] lfsr_state = 16'd23498;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int failed = 0;

    tb_clkgen clkgen_i (.clk(clk), .rst_n(rst_n));

    rob_top rob_top_i (.*);

    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    task check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task clear_entry(input rob_idx_t e);
        m_vld[e] = 1'b0;
        m_done[e] = 1'b0;
        m_rw[e] = 1'b0;
        m_br[e] = 1'b0;
    endtask

    // picks inputs from the model state, called just after a rising edge
    task drive_inputs(input int mode);
        logic [6:0] occ;
        rob_idx_t   idx;
        logic       want_taken;
        occ = m_tail - m_head;
        alloc_vld = (mode == M_FILL || mode == M_PRESS) ? 1'b1 : (rand_bits(2) != 0);
        for (int g = 0; g < `ROB_GRP; g++) begin
            alloc_reg_wrt[g] = (mode == M_FILL) ? 1'b1 : 1'(rand_bits(1));
            alloc_brnc[g] = (mode != M_FILL) && !alloc_reg_wrt[g]
                            && (mode >= M_BR_OK || rand_bits(1));
            alloc_brnc_pred[g] = 1'(rand_bits(1));
            alloc_brnc_cond[g] = brnc_cond_t'(rand_bits(2));
            alloc_free_preg[g] = preg_t'(rand_bits(6));
        end
        for (int p = 0; p < `ROB_DONE_PORTS; p++) begin
            done_vld[p] = 1'b0;
            done_idx[p] = rob_idx_t'(rand_bits(6));
            if (mode != M_FILL && occ != 0) begin
                idx = m_head[5:0] + rob_idx_t'(rand_bits(6) % occ);
                // branches only finish through the branch port
                if (m_vld[idx] && !m_done[idx] && !m_br[idx]
                    && (mode == M_PRESS ? rand_bits(2) == 0 : rand_bits(1))) begin
                    done_vld[p] = 1'b1;
                    done_idx[p] = idx;
                end
            end
        end
        brnc_vld = 1'b0;
        brnc_idx = rob_idx_t'(rand_bits(6));
        brnc_cmp_rslt = brnc_cond_t'(rand_bits(2));
        if (mode != M_FILL && occ != 0 && rand_bits(1)) begin
            idx = m_head[5:0] + rob_idx_t'(rand_bits(6) % occ);
            if (m_vld[idx] && m_br[idx] && !m_done[idx]) begin
                brnc_vld = 1'b1;
                brnc_idx = idx;
                if (mode == M_BR_OK) begin
                    want_taken = m_pred[idx];
                end else if (mode == M_BR_BAD) begin
                    want_taken = !m_pred[idx];
                end else begin
                    want_taken = 1'(rand_bits(1));
                end
                brnc_cmp_rslt = want_taken ? m_cond[idx]
                                           : m_cond[idx] ^ {rand_bits(1) == 1, 1'b1};
            end
        end
    endtask

    // compares the outputs, then moves the model to the next edge
    task check_and_step;
        logic [6:0] occ;
        logic [6:0] klen;
        logic       e_full;
        logic       e_mis;
        logic       hit;
        logic       taken;
        logic       run;
        logic [2:0] cnt;
        logic [2:0] fcnt;
        preg_t      e_fp [`ROB_CMT_W];
        rob_idx_t   idx;
        rob_idx_t   rb;
        occ = m_tail - m_head;
        e_full = (`ROB_DEPTH - occ) < `ROB_GRP;
        hit = brnc_vld && m_vld[brnc_idx] && m_br[brnc_idx];
        taken = (m_cond[brnc_idx] == brnc_cmp_rslt);
        e_mis = hit && (m_pred[brnc_idx] != taken);
        cnt = '0;
        fcnt = '0;
        run = 1'b1;
        for (int k = 0; k < `ROB_CMT_W; k++) begin
            e_fp[k] = '0;
        end
        for (int k = 0; k < `ROB_CMT_W; k++) begin
            idx = m_head[5:0] + rob_idx_t'(k);
            run = run && m_vld[idx] && m_done[idx];
            if (run) begin
                cnt++;
                if (m_rw[idx]) begin
                    e_fp[fcnt] = m_preg[idx];
                    fcnt++;
                end
            end
        end
        check_val("next_idx", next_idx, m_tail);
        check_val("rob_full", rob_full, e_full);
        check_val("rob_empty", rob_empty, occ == 0);
        check_val("mis_pred", mis_pred, e_mis);
        if (e_mis) begin
            check_val("mis_pred_idx", mis_pred_idx, brnc_idx);
        end
        check_val("cmt_brnc", cmt_brnc, hit && !e_mis);
        check_val("commit_cnt", commit_cnt, cnt);
        check_val("free_preg_cnt", free_preg_cnt, fcnt);
        for (int k = 0; k < `ROB_CMT_W; k++) begin
            check_val($sformatf("free_preg[%0d]", k), free_preg[k], e_fp[k]);
        end

        for (int p = 0; p < `ROB_DONE_PORTS; p++) begin
            if (done_vld[p] && m_vld[done_idx[p]]) begin
                m_done[done_idx[p]] = 1'b1;
            end
        end
        if (hit) begin
            m_done[brnc_idx] = 1'b1;
        end
        if (e_mis) begin
            // younger lanes of the branch group turn into bubbles
            for (int e = int'(brnc_idx) + 1; e < (int'(brnc_idx) / 4 + 1) * 4; e++) begin
                m_done[e] = 1'b1;
                m_rw[e] = 1'b0;
                m_br[e] = 1'b0;
            end
            // first entry of the next group, 64 folds back to 0
            rb = rob_idx_t'((int'(brnc_idx) / `ROB_GRP + 1) * `ROB_GRP);
            klen = {1'b0, rob_idx_t'(m_tail[5:0] - rb)};
            for (int k = 0; k < klen; k++) begin
                clear_entry(rb + rob_idx_t'(k));
            end
            m_tail = m_tail - klen;
        end
        for (int k = 0; k < cnt; k++) begin
            clear_entry(m_head[5:0] + rob_idx_t'(k));
        end
        m_head = m_head + rob_ptr_t'(cnt);
        if (alloc_vld && !e_full && !e_mis) begin
            for (int g = 0; g < `ROB_GRP; g++) begin
                idx = m_tail[5:0] + rob_idx_t'(g);
                m_vld[idx] = 1'b1;
                m_rw[idx] = alloc_reg_wrt[g];
                m_br[idx] = alloc_brnc[g];
                m_done[idx] = !(alloc_reg_wrt[g] || alloc_brnc[g]);
                m_pred[idx] = alloc_brnc_pred[g];
                m_cond[idx] = alloc_brnc_cond[g];
                m_preg[idx] = alloc_free_preg[g];
            end
            m_tail = m_tail + rob_ptr_t'(`ROB_GRP);
        end
    endtask

    task run_test(input string name, input int mode, input int cycles);
        int err0;
        err0 = errors;
        repeat (cycles) begin
            @(posedge clk);
            #5;
            drive_inputs(mode);
            @(negedge clk);
            check_and_step();
        end
        tests++;
        if (errors != err0) begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - err0);
        end else begin
            $display("test %s: ok after %0d cycles", name, cycles);
        end
    endtask

    // watchdog sized from the test lengths
    initial begin
        #((TOTAL_CYC + 40) * 100);
        $display("timeout: the run did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        alloc_vld = 1'b0;
        alloc_reg_wrt = '0;
        alloc_brnc = '0;
        alloc_brnc_pred = '0;
        alloc_brnc_cond = '0;
        alloc_free_preg = '0;
        done_vld = '0;
        done_idx = '0;
        brnc_vld = 1'b0;
        brnc_idx = '0;
        brnc_cmp_rslt = '0;
        m_vld = '0;
        m_done = '0;
        m_rw = '0;
        m_br = '0;
        m_pred = '0;
        m_head = '0;
        m_tail = '0;
        wait (rst_n === 1'b1);
        run_test("reset_fill", M_FILL, 17);
        run_test("random_commit", M_RAND, 200);
        run_test("branch_correct", M_BR_OK, 200);
        run_test("mispredict", M_BR_BAD, 200);
        run_test("back_pressure", M_PRESS, 150);
        run_test("wrap_around", M_RAND, 1000);
        @(posedge clk);
        #5;
        alloc_vld = 1'b0;
        done_vld = '0;
        brnc_vld = 1'b0;
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
